//--- Makefile
TOP = tb_btc_enc

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f vlog.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

//--- bench/tb_btc_enc.sv
//------------------------------------------------
// testbench of the BTC product encoder
// loads random frames over Wishbone, runs all nine
// mode pairs and compares the coded frame with a
// reference SPC product code computed here
// also covers the status sequence, protection
// while busy and re-encoding
//------------------------------------------------

`timescale 1ns/1ns

module tb_btc_enc;

  // worst case frame and bus budget for the run limit
  localparam int max_frames   = 20;
  localparam int frame_cycles = 2 * 16 * 8 + 40;
  localparam int bus_cycles   = 256 * 4;
  localparam int cycle_limit  = max_frames * frame_cycles + max_frames * bus_cycles;

  logic                  iclk;
  logic                  ireset;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  btc_regs_pkg::wb_adr_t wb_adr;
  btc_pkg::btc_word_t    wb_dat_w;
  btc_pkg::btc_word_t    wb_dat_r;
  logic                  wb_ack;

  // expected frame, rows by columns
  btc_pkg::btc_word_t ref_frame [16][8];
  int                 cycle_cnt = 0;

  btc_enc_top #(
    .pDAT_W  (btc_pkg::cDAT_W),
    .pADDR_W (btc_pkg::cADDR_W)
  ) dut_i (
    .iclk     (iclk),
    .ireset   (ireset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  initial begin
    iclk = 1'b0;
    forever #20 iclk = ~iclk;
  end

  //------------------------------------------------
  // failure handling and run limit
  //------------------------------------------------

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1);
  endtask

  always @(posedge iclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      stop_run($sformatf("timeout, encoder or bus stuck after %0d cycles", cycle_cnt));
    end
  end

  task automatic check_word(input string name, input btc_pkg::btc_word_t got,
                            input btc_pkg::btc_word_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_status(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  //------------------------------------------------
  // Wishbone classic master
  //------------------------------------------------

  // hold the request until ack, sample ack at the falling edge
  task automatic wb_write(input btc_regs_pkg::wb_adr_t adr, input btc_pkg::btc_word_t dat);
    @(posedge iclk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    do @(negedge iclk); while (wb_ack !== 1'b1);
    @(posedge iclk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  // read data is valid together with ack
  task automatic wb_read(input btc_regs_pkg::wb_adr_t adr, output btc_pkg::btc_word_t dat);
    @(posedge iclk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    do @(negedge iclk); while (wb_ack !== 1'b1);
    dat = wb_dat_r;
    @(posedge iclk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  //------------------------------------------------
  // reference and address helpers
  //------------------------------------------------

  // window bit, then row above the 3 column bits
  function automatic btc_regs_pkg::wb_adr_t frame_adr(input int r, input int c);
    return btc_regs_pkg::wb_adr_t'((1 << btc_regs_pkg::cFRAME_BIT) | (r << 3) | c);
  endfunction

  function automatic btc_pkg::btc_word_t ctrl_value(input int xi, input int yi, input bit go);
    btc_pkg::btc_word_t v;
    v = '0;
    v[btc_regs_pkg::cCTRL_XMODE +: 2] = xi[1:0];
    v[btc_regs_pkg::cCTRL_YMODE +: 2] = yi[1:0];
    v[btc_regs_pkg::cCTRL_START]      = go;
    return v;
  endfunction

  // SPC product rule, rows first, then every code column
  function automatic void btc_ref_encode(input int code_words, input int code_rows);
    btc_pkg::btc_word_t acc;
    for (int r = 0; r < code_rows - 1; r++) begin
      acc = '0;
      for (int c = 0; c < code_words - 1; c++) begin
        acc = acc ^ ref_frame[r][c];
      end
      ref_frame[r][code_words-1] = acc;
    end
    // check on checks comes out of the parity column
    for (int c = 0; c < code_words; c++) begin
      acc = '0;
      for (int r = 0; r < code_rows - 1; r++) begin
        acc = acc ^ ref_frame[r][c];
      end
      ref_frame[code_rows-1][c] = acc;
    end
  endfunction

  //------------------------------------------------
  // frame level steps
  //------------------------------------------------

  // random data words only, parity places left as they are
  task automatic load_frame(input int xi, input int yi);
    for (int r = 0; r < (4 << yi) - 1; r++) begin
      for (int c = 0; c < (2 << xi) - 1; c++) begin
        ref_frame[r][c] = btc_pkg::btc_word_t'($urandom);
        wb_write(frame_adr(r, c), ref_frame[r][c]);
      end
    end
  endtask

  // start clears done, first poll must see busy
  task automatic launch(input int xi, input int yi);
    btc_pkg::btc_word_t st;
    wb_write(btc_regs_pkg::cREG_CTRL, ctrl_value(xi, yi, 1'b1));
    wb_read(btc_regs_pkg::cREG_STATUS, st);
    check_status("status after start", st, 8'(1 << btc_regs_pkg::cSTAT_BUSY));
  endtask

  task automatic wait_done();
    btc_pkg::btc_word_t st;
    do begin
      wb_read(btc_regs_pkg::cREG_STATUS, st);
    end while (st[btc_regs_pkg::cSTAT_DONE] !== 1'b1);
    check_status("status at done", st, 8'(1 << btc_regs_pkg::cSTAT_DONE));
  endtask

  // modes as written, start bit back at 0
  task automatic check_mode(input int xi, input int yi);
    btc_pkg::btc_word_t v;
    wb_read(btc_regs_pkg::cREG_CTRL, v);
    check_word("ctrl", v, ctrl_value(xi, yi, 1'b0));
  endtask

  task automatic verify_frame(input int xi, input int yi);
    btc_pkg::btc_word_t got;
    btc_ref_encode(2 << xi, 4 << yi);
    for (int r = 0; r < (4 << yi); r++) begin
      for (int c = 0; c < (2 << xi); c++) begin
        wb_read(frame_adr(r, c), got);
        check_word($sformatf("wb_dat_r row %0d col %0d", r, c), got, ref_frame[r][c]);
      end
    end
  endtask

  task automatic encode_and_check(input int xi, input int yi);
    load_frame(xi, yi);
    launch(xi, yi);
    wait_done();
    check_mode(xi, yi);
    verify_frame(xi, yi);
  endtask

  //------------------------------------------------
  // test sequence
  //------------------------------------------------

  initial begin
    btc_pkg::btc_word_t v;
    void'($urandom(44));
    ireset   = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    repeat (10) @(posedge iclk);
    ireset <= 1'b0;

    // idle status and mode readback
    wb_read(btc_regs_pkg::cREG_STATUS, v);
    check_status("status after reset", v, 8'h00);
    wb_write(btc_regs_pkg::cREG_CTRL, ctrl_value(2, 1, 1'b0));
    check_mode(2, 1);

    // largest first, so stale parity sits under later frames
    for (int xi = 2; xi >= 0; xi--) begin
      for (int yi = 2; yi >= 0; yi--) begin
        encode_and_check(xi, yi);
      end
    end

    // frame write, frame read and second start during the row pass
    load_frame(2, 2);
    launch(2, 2);
    wb_write(frame_adr(0, 0), ~ref_frame[0][0]);
    // frame window reads as zero while encoding
    wb_read(frame_adr(0, 0), v);
    check_word("wb_dat_r while busy", v, 8'h00);
    wb_write(btc_regs_pkg::cREG_CTRL, ctrl_value(0, 0, 1'b1));
    wait_done();
    check_mode(2, 2);
    verify_frame(2, 2);

    // new modes and new data over the full size frame
    encode_and_check(1, 1);

    $display("** PASS **");
    $finish;
  end

endmodule

//--- logic/btc_enc_ctrl.sv
//------------------------------------------------
// BTC encoder sequencer
// walks the frame buffer once by rows and then by
// columns, driving read address and framing flags
// for the SPC accumulator
// waits on the accumulator between passes
//------------------------------------------------

`timescale 1ns/1ns

module btc_enc_ctrl #(
  parameter int pADDR_W = 7
) (
  input  logic                    iclk,
  input  logic                    ireset,
  input  logic                    start,
  input  btc_pkg::btc_xmode_t     xmode,
  input  btc_pkg::btc_ymode_t     ymode,
  output logic                    busy,
  output logic                    done,
  output logic [pADDR_W-1:0]      buf_addr,
  output logic                    row_mode,
  output logic                    enc_sop,
  output logic                    enc_eop,
  output logic                    enc_val,
  input  logic                    enc_busy
);

  typedef enum logic [2:0] {
    cRESET_STATE,
    cWAIT_STATE,
    cDO_ROW_STATE,
    cWAIT_ROW_STATE,
    cDO_COL_STATE,
    cWAIT_COL_STATE,
    cDONE_STATE
  } state_t;

  state_t state;

  btc_pkg::btc_col_t col_idx;
  btc_pkg::btc_col_t col_nxt;
  btc_pkg::btc_row_t row_idx;
  btc_pkg::btc_row_t row_nxt;
  logic              col_last;
  logic              row_last;

  // last indices for the current mode
  btc_pkg::btc_col_t data_col_max;
  btc_pkg::btc_col_t code_col_max;
  btc_pkg::btc_row_t data_row_max;

  //------------------------------------------------
  // frame geometry
  //------------------------------------------------

  // last data column, parity sits one further
  assign data_col_max = btc_pkg::btc_col_t'(btc_pkg::get_code_words(xmode) - 4'd2);
  // column pass also covers the parity column
  assign code_col_max = btc_pkg::btc_col_t'(btc_pkg::get_code_words(xmode) - 4'd1);
  // only data rows are read in both passes
  assign data_row_max = btc_pkg::btc_row_t'(btc_pkg::get_code_rows(ymode) - 5'd2);

  //------------------------------------------------
  // FSM
  //------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= cRESET_STATE;
    end else begin
      case (state)
        cRESET_STATE    : state <= cWAIT_STATE;
        cWAIT_STATE     : state <= start ? cDO_ROW_STATE : cWAIT_STATE;
        // leave after the last data word of the last data row
        cDO_ROW_STATE   : state <= (col_last & row_last) ? cWAIT_ROW_STATE : cDO_ROW_STATE;
        // row parity must land before the columns read it
        cWAIT_ROW_STATE : state <= enc_busy ? cWAIT_ROW_STATE : cDO_COL_STATE;
        cDO_COL_STATE   : state <= (col_last & row_last) ? cWAIT_COL_STATE : cDO_COL_STATE;
        cWAIT_COL_STATE : state <= enc_busy ? cWAIT_COL_STATE : cDONE_STATE;
        cDONE_STATE     : state <= cWAIT_STATE;
        default         : state <= cRESET_STATE;
      endcase
    end
  end

  //------------------------------------------------
  // frame counters
  //------------------------------------------------

  // wrap to zero after the flagged last index
  assign col_nxt = col_last ? '0 : col_idx + 1'b1;
  assign row_nxt = row_last ? '0 : row_idx + 1'b1;

  // last flags are registered one step ahead of the index
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      col_idx  <= '0;
      row_idx  <= '0;
      col_last <= 1'b0;
      row_last <= 1'b0;
    end else begin
      case (state)
        // prepare the row pass
        cWAIT_STATE : begin
          col_idx  <= '0;
          row_idx  <= '0;
          col_last <= (data_col_max == '0);
          row_last <= (data_row_max == '0);
        end
        // column index inner, data columns only
        cDO_ROW_STATE : begin
          col_idx  <= col_nxt;
          col_last <= (col_nxt == data_col_max);
          if (col_last) begin
            row_idx  <= row_nxt;
            row_last <= (row_nxt == data_row_max);
          end
        end
        // prepare the column pass
        cWAIT_ROW_STATE : begin
          col_idx  <= '0;
          row_idx  <= '0;
          col_last <= (code_col_max == '0);
          row_last <= (data_row_max == '0);
        end
        // row index inner, all code columns
        cDO_COL_STATE : begin
          row_idx  <= row_nxt;
          row_last <= (row_nxt == data_row_max);
          if (row_last) begin
            col_idx  <= col_nxt;
            col_last <= (col_nxt == code_col_max);
          end
        end
        default : begin
        end
      endcase
    end
  end

  //------------------------------------------------
  // outputs
  //------------------------------------------------

  assign buf_addr = pADDR_W'({row_idx, col_idx});

  // wait row state keeps the mode for the last parity write
  assign row_mode = (state == cDO_ROW_STATE) | (state == cWAIT_ROW_STATE);

  assign enc_val = (state == cDO_ROW_STATE) | (state == cDO_COL_STATE);
  assign enc_sop = row_mode ? (col_idx == '0) : (row_idx == '0);
  assign enc_eop = row_mode ? col_last : row_last;

  assign busy = (state != cRESET_STATE) & (state != cWAIT_STATE);
  assign done = (state == cDONE_STATE);

endmodule

//--- logic/btc_enc_top.sv
//------------------------------------------------
// BTC product encoder top level
// host loads a frame over Wishbone, sets the modes
// and start, polls status and reads the coded frame
//------------------------------------------------

`timescale 1ns/1ns

module btc_enc_top #(
  parameter int pDAT_W  = btc_pkg::cDAT_W,
  parameter int pADDR_W = btc_pkg::cADDR_W
) (
  input  logic                  iclk,
  input  logic                  ireset,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  btc_regs_pkg::wb_adr_t wb_adr,
  input  btc_pkg::btc_word_t    wb_dat_w,
  output btc_pkg::btc_word_t    wb_dat_r,
  output logic                  wb_ack
);

  // register block and sequencer
  logic                start;
  logic                busy;
  logic                done;
  btc_pkg::btc_xmode_t xmode;
  btc_pkg::btc_ymode_t ymode;

  // host port of the memory
  logic                host_we;
  logic [pADDR_W-1:0]  host_addr;
  btc_pkg::btc_word_t  host_wdata;
  btc_pkg::btc_word_t  host_rdata;

  // encoder path
  logic [pADDR_W-1:0]  buf_addr;
  logic                row_mode;
  logic                enc_sop;
  logic                enc_eop;
  logic                enc_val;
  logic                enc_busy;
  logic [pDAT_W-1:0]   enc_rdata;
  logic                par_we;
  logic [pADDR_W-1:0]  par_addr;
  logic [pDAT_W-1:0]   par_data;

  btc_wb_regs #(
    .pADDR_W (pADDR_W)
  ) u_regs (
    .iclk       (iclk),
    .ireset     (ireset),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .start      (start),
    .xmode      (xmode),
    .ymode      (ymode),
    .busy       (busy),
    .done       (done),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata)
  );

  btc_enc_ctrl #(
    .pADDR_W (pADDR_W)
  ) u_ctrl (
    .iclk     (iclk),
    .ireset   (ireset),
    .start    (start),
    .xmode    (xmode),
    .ymode    (ymode),
    .busy     (busy),
    .done     (done),
    .buf_addr (buf_addr),
    .row_mode (row_mode),
    .enc_sop  (enc_sop),
    .enc_eop  (enc_eop),
    .enc_val  (enc_val),
    .enc_busy (enc_busy)
  );

  btc_spc_enc #(
    .pDAT_W  (pDAT_W),
    .pADDR_W (pADDR_W)
  ) u_spc (
    .iclk      (iclk),
    .ireset    (ireset),
    .buf_addr  (buf_addr),
    .row_mode  (row_mode),
    .enc_sop   (enc_sop),
    .enc_eop   (enc_eop),
    .enc_val   (enc_val),
    .enc_rdata (enc_rdata),
    .enc_busy  (enc_busy),
    .par_we    (par_we),
    .par_addr  (par_addr),
    .par_data  (par_data)
  );

  // in place encoding, parity lands in the same buffer
  btc_frame_ram #(
    .pDAT_W  (pDAT_W),
    .pADDR_W (pADDR_W)
  ) u_ram (
    .iclk       (iclk),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata),
    .enc_raddr  (buf_addr),
    .enc_rdata  (enc_rdata),
    .par_we     (par_we),
    .par_addr   (par_addr),
    .par_data   (par_data)
  );

endmodule

//--- logic/btc_frame_ram.sv
//------------------------------------------------
// frame buffer of the BTC encoder
// one write port shared by host and parity writer,
// registered reads for host and sequencer
//------------------------------------------------

`timescale 1ns/1ns

module btc_frame_ram #(
  parameter int pDAT_W  = 8,
  parameter int pADDR_W = 7
) (
  input  logic               iclk,
  input  logic               host_we,
  input  logic [pADDR_W-1:0] host_addr,
  input  logic [pDAT_W-1:0]  host_wdata,
  output logic [pDAT_W-1:0]  host_rdata,
  input  logic [pADDR_W-1:0] enc_raddr,
  output logic [pDAT_W-1:0]  enc_rdata,
  input  logic               par_we,
  input  logic [pADDR_W-1:0] par_addr,
  input  logic [pDAT_W-1:0]  par_data
);

  logic [pDAT_W-1:0] mem [2**pADDR_W];

  // parity writer first
  // host writes are already blocked while encoding
  always_ff @(posedge iclk) begin
    if (par_we) begin
      mem[par_addr] <= par_data;
    end else if (host_we) begin
      mem[host_addr] <= host_wdata;
    end
  end

  // one cycle read latency on both ports
  always_ff @(posedge iclk) begin
    host_rdata <= mem[host_addr];
    enc_rdata  <= mem[enc_raddr];
  end

endmodule

//--- logic/btc_pkg.sv
//------------------------------------------------
// code geometry for the BTC product encoder
// mode enums, width typedefs and the length
// functions shared by the sequencer and the bus side
// referenced by scoped names only
//------------------------------------------------

package btc_pkg;

  // default word width and frame address split
  localparam int cDAT_W  = 8;
  localparam int cCOL_W  = 3;
  localparam int cROW_W  = 4;
  localparam int cADDR_W = cROW_W + cCOL_W;

  typedef logic [cDAT_W-1:0] btc_word_t;
  typedef logic [cCOL_W-1:0] btc_col_t;
  typedef logic [cROW_W-1:0] btc_row_t;

  // code row length in words
  typedef enum logic [1:0] {
    cX2,
    cX4,
    cX8
  } btc_xmode_t;

  // code column length in rows
  typedef enum logic [1:0] {
    cY4,
    cY8,
    cY16
  } btc_ymode_t;

  // words per code row, parity word included
  function automatic logic [3:0] get_code_words(btc_xmode_t xmode);
    case (xmode)
      cX2     : return 4'd2;
      cX4     : return 4'd4;
      // unused encoding falls back to the widest row
      default : return 4'd8;
    endcase
  endfunction

  // rows per code column, parity row included
  function automatic logic [4:0] get_code_rows(btc_ymode_t ymode);
    case (ymode)
      cY4     : return 5'd4;
      cY8     : return 5'd8;
      default : return 5'd16;
    endcase
  endfunction

endpackage

//--- logic/btc_regs_pkg.sv
//------------------------------------------------
// register map of the BTC encoder host port
// Wishbone address fields, register offsets and
// control and status bit positions
//------------------------------------------------

package btc_regs_pkg;

  typedef logic [7:0] wb_adr_t;

  // address bit 7 opens the frame window
  localparam int cFRAME_BIT = 7;

  // register offsets with the window bit clear
  localparam wb_adr_t cREG_CTRL   = 8'h00;
  localparam wb_adr_t cREG_STATUS = 8'h01;

  // control register
  localparam int cMODE_W     = 2;
  localparam int cCTRL_XMODE = 0;
  localparam int cCTRL_YMODE = 2;
  // write one to launch, reads back as 0
  localparam int cCTRL_START = 4;

  // status register
  localparam int cSTAT_BUSY = 0;
  localparam int cSTAT_DONE = 1;

endpackage

//--- logic/btc_spc_enc.sv
//------------------------------------------------
// single parity check accumulator
// lines the sequencer flags up with the frame
// memory read data, XORs one code line and writes
// the parity word right after its last data word
//------------------------------------------------

`timescale 1ns/1ns

module btc_spc_enc #(
  parameter int pDAT_W  = 8,
  parameter int pADDR_W = 7
) (
  input  logic               iclk,
  input  logic               ireset,
  input  logic [pADDR_W-1:0] buf_addr,
  input  logic               row_mode,
  input  logic               enc_sop,
  input  logic               enc_eop,
  input  logic               enc_val,
  input  logic [pDAT_W-1:0]  enc_rdata,
  output logic               enc_busy,
  output logic               par_we,
  output logic [pADDR_W-1:0] par_addr,
  output logic [pDAT_W-1:0]  par_data
);

  // next word in a row, next row in a column
  localparam logic [pADDR_W-1:0] cCOL_STEP = pADDR_W'(1);
  localparam logic [pADDR_W-1:0] cROW_STEP = pADDR_W'(1) << btc_pkg::cCOL_W;

  logic               val_q;
  logic               sop_q;
  logic               eop_q;
  logic [pADDR_W-1:0] addr_q;
  logic [pDAT_W-1:0]  acc;

  //------------------------------------------------
  // memory latency stage
  //------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_q <= 1'b0;
      sop_q <= 1'b0;
      eop_q <= 1'b0;
    end else begin
      val_q <= enc_val;
      sop_q <= enc_sop;
      eop_q <= enc_eop;
    end
  end

  // running sum, restarted by sop
  always_ff @(posedge iclk) begin
    addr_q <= buf_addr;
    if (val_q) begin
      acc <= par_data;
    end
  end

  //------------------------------------------------
  // parity write
  //------------------------------------------------

  assign par_data = (sop_q ? '0 : acc) ^ enc_rdata;
  assign par_we   = val_q & eop_q;
  assign par_addr = addr_q + (row_mode ? cCOL_STEP : cROW_STEP);

  // the parity write goes out with the last registered word,
  // so nothing is left once val_q drops
  assign enc_busy = val_q;

endmodule

//--- logic/btc_wb_regs.sv
//------------------------------------------------
// Wishbone classic slave of the BTC encoder
// holds control and status, and maps the frame
// buffer at address bit 7
// ack follows a new request by one clock
//------------------------------------------------

`timescale 1ns/1ns

module btc_wb_regs #(
  parameter int pADDR_W = 7
) (
  input  logic                  iclk,
  input  logic                  ireset,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  btc_regs_pkg::wb_adr_t wb_adr,
  input  btc_pkg::btc_word_t    wb_dat_w,
  output btc_pkg::btc_word_t    wb_dat_r,
  output logic                  wb_ack,
  output logic                  start,
  output btc_pkg::btc_xmode_t   xmode,
  output btc_pkg::btc_ymode_t   ymode,
  input  logic                  busy,
  input  logic                  done,
  output logic                  host_we,
  output logic [pADDR_W-1:0]    host_addr,
  output btc_pkg::btc_word_t    host_wdata,
  input  btc_pkg::btc_word_t    host_rdata
);

  logic               req;
  logic               sel_frame;
  logic               ctrl_wr;
  logic               done_sticky;
  logic               frame_rd_q;
  logic               rd_zero_q;
  btc_pkg::btc_word_t ctrl_word;
  btc_pkg::btc_word_t stat_word;
  btc_pkg::btc_word_t reg_rdata;

  //------------------------------------------------
  // address decode
  //------------------------------------------------

  // new request only while ack is low
  assign req       = wb_cyc & wb_stb & ~wb_ack;
  assign sel_frame = wb_adr[btc_regs_pkg::cFRAME_BIT];

  // frame window straight into the memory host port
  assign host_addr  = wb_adr[pADDR_W-1:0];
  assign host_wdata = wb_dat_w;
  assign host_we    = req & wb_we & sel_frame & ~busy;

  // mode and start frozen during encoding
  assign ctrl_wr = req & wb_we & (wb_adr == btc_regs_pkg::cREG_CTRL) & ~busy;

  //------------------------------------------------
  // control and status
  //------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wb_ack      <= 1'b0;
      start       <= 1'b0;
      xmode       <= btc_pkg::cX2;
      ymode       <= btc_pkg::cY4;
      done_sticky <= 1'b0;
      frame_rd_q  <= 1'b0;
      rd_zero_q   <= 1'b0;
    end else begin
      wb_ack <= req;
      // start pulse lines up with ack
      start  <= ctrl_wr & wb_dat_w[btc_regs_pkg::cCTRL_START];
      if (ctrl_wr) begin
        xmode <= btc_pkg::btc_xmode_t'(
                   wb_dat_w[btc_regs_pkg::cCTRL_XMODE +: btc_regs_pkg::cMODE_W]);
        ymode <= btc_pkg::btc_ymode_t'(
                   wb_dat_w[btc_regs_pkg::cCTRL_YMODE +: btc_regs_pkg::cMODE_W]);
      end
      // sticky until the next launch
      if (done) begin
        done_sticky <= 1'b1;
      end else if (start) begin
        done_sticky <= 1'b0;
      end
      if (req) begin
        frame_rd_q <= sel_frame;
        rd_zero_q  <= busy;
      end
    end
  end

  //------------------------------------------------
  // read back
  //------------------------------------------------

  always_comb begin
    ctrl_word = '0;
    ctrl_word[btc_regs_pkg::cCTRL_XMODE +: btc_regs_pkg::cMODE_W] = xmode;
    ctrl_word[btc_regs_pkg::cCTRL_YMODE +: btc_regs_pkg::cMODE_W] = ymode;
    stat_word = '0;
    stat_word[btc_regs_pkg::cSTAT_BUSY] = busy;
    stat_word[btc_regs_pkg::cSTAT_DONE] = done_sticky;
  end

  always_ff @(posedge iclk) begin
    if (req) begin
      case (wb_adr)
        btc_regs_pkg::cREG_CTRL   : reg_rdata <= ctrl_word;
        btc_regs_pkg::cREG_STATUS : reg_rdata <= stat_word;
        default                   : reg_rdata <= '0;
      endcase
    end
  end

  // frame data comes from the memory one clock later, zero while encoding
  assign wb_dat_r = frame_rd_q ? (rd_zero_q ? '0 : host_rdata) : reg_rdata;

endmodule

//--- vlog.f
logic/btc_pkg.sv
logic/btc_regs_pkg.sv
logic/btc_frame_ram.sv
logic/btc_spc_enc.sv
logic/btc_enc_ctrl.sv
logic/btc_wb_regs.sv
logic/btc_enc_top.sv
bench/tb_btc_enc.sv
